/* design/isa_pkg.sv */
package isa_pkg;

    // basic widths of the mips subset
    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  reg_idx_t;   // register file index
    typedef logic [5:0]  opcode_t;    // instr[31:26]
    typedef logic [5:0]  funct_t;     // instr[5:0], r-type only
    typedef logic [15:0] imm16_t;     // i-type immediate
    typedef logic [25:0] target26_t;  // j-type target field

    // register file depth, fixed by the isa
    localparam int NUM_REGS = 32;

    // jal always links here
    localparam reg_idx_t LINK_REG = 5'd31;

    // primary opcodes
    localparam opcode_t R_TYPE   = 6'b000000;
    localparam opcode_t ADDIU_OP = 6'b001001;
    localparam opcode_t LBU_OP   = 6'b100100;
    localparam opcode_t SB_OP    = 6'b101000;
    localparam opcode_t BGTZ_OP  = 6'b000111;
    localparam opcode_t JAL_OP   = 6'b000011;
    localparam opcode_t LUI_OP   = 6'b001111;

    // function codes under R_TYPE
    localparam funct_t SUBU_FUNCT = 6'b100011;
    localparam funct_t JR_FUNCT   = 6'b001000;

    // field positions inside an instruction word
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;

    // pc steps
    localparam word_t PC_STEP = 32'd4;  // next sequential instruction
    localparam word_t PC_LINK = 32'd8;  // return address past the delay slot

endpackage

/* design/ctrl_pkg.sv */
package ctrl_pkg;

    // alu operation, add is zero so an empty control word stays harmless
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_LUI = 2'd2   // immediate into upper half
    } alu_op_e;

    // access size, only bytes in this subset
    typedef enum logic {
        MEM_BYTE = 1'b0,
        MEM_WORD = 1'b1
    } mem_size_e;

    // decoded control word
    typedef struct packed {
        logic      src_imm;       // operand b is the immediate
        logic      imm_sign_ext;  // sign vs zero extend of imm16
        alu_op_e   alu_op;
        logic      rf_enable;     // writes a register
        logic      dest_rd;       // rd instead of rt
        logic      link;          // r31 <= pc+8
        logic      load;
        logic      mem_enable;
        logic      mem_write;
        mem_size_e mem_size;
        logic      branch;        // conditional, pc relative
        logic      jump;          // j-type target
        logic      jump_reg;      // target from rs
    } ctrl_word_t;

    // decode stage bundle into execute
    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        isa_pkg::reg_idx_t  rs;
        isa_pkg::reg_idx_t  rt;
        isa_pkg::reg_idx_t  rd;
        isa_pkg::imm16_t    imm16;
        isa_pkg::target26_t target26;
        ctrl_word_t         ctrl;
    } decode_t;

    // execute result into commit
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    alu_result;   // also the memory address
        isa_pkg::word_t    store_data;
        isa_pkg::reg_idx_t dest;
        logic              load;
        logic              mem_enable;
        logic              mem_write;
        logic              rf_enable;
        logic              redirect;     // taken branch or any jump
        isa_pkg::word_t    redirect_pc;
    } exec_t;

endpackage

/* design/instr_intake.sv */
module instr_intake (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  isa_pkg::word_t instr,
    input  isa_pkg::word_t pc,
    output isa_pkg::word_t dec_instr,
    output isa_pkg::word_t dec_pc,
    output logic           dec_valid
);

    // strobe register, the only control state here
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // payload, a missing strobe loads a zero word
    // so the bubble decodes to an empty control word
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_instr <= instr;
            dec_pc    <= pc;
        end else begin
            dec_instr <= '0;  // nop
            dec_pc    <= '0;
        end
    end

endmodule

/* design/ppu_control_unit.sv */
module ppu_control_unit (
    input  isa_pkg::word_t      instr,
    output ctrl_pkg::ctrl_word_t ctrl
);

    isa_pkg::opcode_t opcode;
    isa_pkg::funct_t  funct;

    assign opcode = instr[31:isa_pkg::OPCODE_LSB];
    assign funct  = instr[5:0];

    // priority chain, specific r-type functs before the generic r-type arm
    always_comb begin
        ctrl = '0;  // default, unknown code does nothing
        if (instr == '0) begin
            ctrl = '0;  // explicit nop
        end else if (opcode == isa_pkg::R_TYPE && funct == isa_pkg::SUBU_FUNCT) begin
            ctrl.alu_op    = ctrl_pkg::ALU_SUB;
            ctrl.rf_enable = 1'b1;
            ctrl.dest_rd   = 1'b1;  // rd = rs - rt
        end else if (opcode == isa_pkg::R_TYPE && funct == isa_pkg::JR_FUNCT) begin
            ctrl.jump_reg = 1'b1;  // no write-back
        end else if (opcode == isa_pkg::R_TYPE) begin
            ctrl = '0;  // other functs not supported
        end else if (opcode == isa_pkg::ADDIU_OP) begin
            ctrl.src_imm      = 1'b1;
            ctrl.imm_sign_ext = 1'b1;  // sign extended despite the "u"
            ctrl.alu_op       = ctrl_pkg::ALU_ADD;
            ctrl.rf_enable    = 1'b1;
        end else if (opcode == isa_pkg::LBU_OP) begin
            ctrl.src_imm      = 1'b1;
            ctrl.imm_sign_ext = 1'b1;  // signed offset
            ctrl.alu_op       = ctrl_pkg::ALU_ADD;
            ctrl.rf_enable    = 1'b1;
            ctrl.load         = 1'b1;
            ctrl.mem_enable   = 1'b1;
            ctrl.mem_size     = ctrl_pkg::MEM_BYTE;
        end else if (opcode == isa_pkg::SB_OP) begin
            ctrl.src_imm      = 1'b1;
            ctrl.imm_sign_ext = 1'b1;
            ctrl.alu_op       = ctrl_pkg::ALU_ADD;
            ctrl.mem_enable   = 1'b1;
            ctrl.mem_write    = 1'b1;
            ctrl.mem_size     = ctrl_pkg::MEM_BYTE;
        end else if (opcode == isa_pkg::BGTZ_OP) begin
            ctrl.imm_sign_ext = 1'b1;  // offset is signed
            ctrl.branch       = 1'b1;
        end else if (opcode == isa_pkg::JAL_OP) begin
            ctrl.rf_enable = 1'b1;
            ctrl.link      = 1'b1;  // r31 <= pc+8
            ctrl.jump      = 1'b1;
        end else if (opcode == isa_pkg::LUI_OP) begin
            ctrl.src_imm   = 1'b1;
            ctrl.alu_op    = ctrl_pkg::ALU_LUI;
            ctrl.rf_enable = 1'b1;
        end
    end

endmodule

/* design/reg_file.sv */
module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::reg_idx_t rs,
    input  isa_pkg::reg_idx_t rt,
    output isa_pkg::word_t    rs_data,
    output isa_pkg::word_t    rt_data,
    input  logic              we,
    input  isa_pkg::reg_idx_t wr_reg,
    input  isa_pkg::word_t    wr_data
);

    isa_pkg::word_t regs [isa_pkg::NUM_REGS];

    // r0 is never written so it reads zero forever
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_reg != '0) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // async reads with write-through, covers the third issue slot
    always_comb begin
        rs_data = regs[rs];
        rt_data = regs[rt];
        if (we && wr_reg != '0 && wr_reg == rs) rs_data = wr_data;
        if (we && wr_reg != '0 && wr_reg == rt) rt_data = wr_data;
    end

endmodule

/* design/exec_unit.sv */
module exec_unit (
    input  logic              clk,
    input  logic              reset,
    input  ctrl_pkg::decode_t dec,
    input  isa_pkg::word_t    rs_data,
    input  isa_pkg::word_t    rt_data,
    output ctrl_pkg::exec_t   ex
);

    isa_pkg::word_t    imm_ext;     // extended immediate
    isa_pkg::word_t    op_b;
    isa_pkg::word_t    alu_res;
    isa_pkg::word_t    pc_plus4;
    isa_pkg::word_t    br_target;
    isa_pkg::word_t    jmp_target;
    logic              br_taken;
    ctrl_pkg::exec_t   ex_d;        // next value of the stage register

    // operand b and alu
    always_comb begin
        if (dec.ctrl.imm_sign_ext) begin
            imm_ext = {{16{dec.imm16[15]}}, dec.imm16};
        end else begin
            imm_ext = {16'b0, dec.imm16};
        end
        op_b = dec.ctrl.src_imm ? imm_ext : rt_data;
        case (dec.ctrl.alu_op)
            ctrl_pkg::ALU_ADD: alu_res = rs_data + op_b;
            ctrl_pkg::ALU_SUB: alu_res = rs_data - op_b;
            ctrl_pkg::ALU_LUI: alu_res = {op_b[15:0], 16'b0};  // rs ignored
            default:           alu_res = '0;
        endcase
    end

    // branch and jump targets
    assign pc_plus4   = dec.pc + isa_pkg::PC_STEP;
    assign br_target  = pc_plus4 + {{14{dec.imm16[15]}}, dec.imm16, 2'b00};  // word offset
    assign jmp_target = {pc_plus4[31:28], dec.target26, 2'b00};  // same 256MB region
    assign br_taken   = dec.ctrl.branch && !rs_data[31] && (rs_data != '0);  // rs > 0 signed

    always_comb begin
        ex_d            = '0;
        ex_d.valid      = dec.valid;
        ex_d.alu_result = dec.ctrl.link ? dec.pc + isa_pkg::PC_LINK : alu_res;
        ex_d.store_data = rt_data;  // sb source
        ex_d.load       = dec.ctrl.load;
        ex_d.mem_enable = dec.ctrl.mem_enable;
        ex_d.mem_write  = dec.ctrl.mem_write;
        ex_d.rf_enable  = dec.ctrl.rf_enable;
        // destination, link wins over rd/rt
        if (dec.ctrl.link) begin
            ex_d.dest = isa_pkg::LINK_REG;
        end else if (dec.ctrl.dest_rd) begin
            ex_d.dest = dec.rd;
        end else begin
            ex_d.dest = dec.rt;
        end
        ex_d.redirect = br_taken || dec.ctrl.jump || dec.ctrl.jump_reg;
        if (dec.ctrl.jump_reg) begin
            ex_d.redirect_pc = rs_data;  // jr
        end else if (dec.ctrl.jump) begin
            ex_d.redirect_pc = jmp_target;  // jal
        end else begin
            ex_d.redirect_pc = br_target;  // bgtz
        end
    end

    // execute stage register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex <= '0;
        end else begin
            ex <= ex_d;
        end
    end

endmodule

/* design/commit_stage.sv */
module commit_stage #(
    parameter int DMEM_BYTES = 256
) (
    input  logic              clk,
    input  logic              reset,
    input  ctrl_pkg::exec_t   ex,
    output logic              wb_valid,
    output isa_pkg::reg_idx_t wb_reg,
    output isa_pkg::word_t    wb_data,
    output logic              redirect_valid,
    output isa_pkg::word_t    redirect_pc
);

    logic [7:0]     dmem [DMEM_BYTES];  // byte data memory
    isa_pkg::word_t addr;
    logic [7:0]     rd_byte;
    logic           st_en;

    assign addr    = ex.alu_result % DMEM_BYTES;  // wraps around
    assign rd_byte = dmem[addr];  // combinational read
    assign st_en   = ex.valid && ex.mem_enable && ex.mem_write;

    // sb writes the low byte of rt
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_BYTES; i++) begin
                dmem[i] <= '0;
            end
        end else if (st_en) begin
            dmem[addr] <= ex.store_data[7:0];
        end
    end

    // strobes, r0 targets never pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            wb_valid       <= ex.valid && ex.rf_enable && (ex.dest != '0);
            redirect_valid <= ex.valid && ex.redirect;
        end
    end

    // payloads, lbu zero-extends
    always_ff @(posedge clk) begin
        wb_reg      <= ex.dest;
        wb_data     <= ex.load ? {24'b0, rd_byte} : ex.alu_result;
        redirect_pc <= ex.redirect_pc;
    end

endmodule

/* design/ppu_core_top.sv */
module ppu_core_top #(
    parameter int DMEM_BYTES = 256
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  isa_pkg::word_t    instr,
    input  isa_pkg::word_t    pc,
    output logic              wb_valid,
    output isa_pkg::reg_idx_t wb_reg,
    output isa_pkg::word_t    wb_data,
    output logic              redirect_valid,
    output isa_pkg::word_t    redirect_pc
);

    isa_pkg::word_t       dec_instr;
    isa_pkg::word_t       dec_pc;
    logic                 dec_valid;
    ctrl_pkg::ctrl_word_t ctrl;
    ctrl_pkg::decode_t    dec;
    isa_pkg::word_t       rs_data;
    isa_pkg::word_t       rt_data;
    ctrl_pkg::exec_t      ex;

    instr_intake u_intake (
        .clk, .reset, .in_valid, .instr, .pc, .dec_instr, .dec_pc, .dec_valid
    );

    ppu_control_unit u_ctrl (
        .instr (dec_instr),
        .ctrl  (ctrl)
    );

    // instruction fields into the decode bundle
    assign dec.valid    = dec_valid;
    assign dec.pc       = dec_pc;
    assign dec.rs       = dec_instr[isa_pkg::RS_LSB +: 5];
    assign dec.rt       = dec_instr[isa_pkg::RT_LSB +: 5];
    assign dec.rd       = dec_instr[isa_pkg::RD_LSB +: 5];
    assign dec.imm16    = dec_instr[15:0];
    assign dec.target26 = dec_instr[25:0];
    assign dec.ctrl     = ctrl;

    // write port fed straight from the commit registers
    reg_file u_rf (
        .clk, .reset, .rs (dec.rs), .rt (dec.rt), .rs_data, .rt_data,
        .we (wb_valid), .wr_reg (wb_reg), .wr_data (wb_data)
    );

    exec_unit u_exec (
        .clk, .reset, .dec, .rs_data, .rt_data, .ex
    );

    commit_stage #(.DMEM_BYTES(DMEM_BYTES)) u_commit (
        .clk, .reset, .ex, .wb_valid, .wb_reg, .wb_data, .redirect_valid, .redirect_pc
    );

endmodule

/* bench/tb_ppu_core.sv */
module tb_ppu_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DMEM_BYTES = 256;
    localparam int SEED       = 69960;
    localparam int N_RANDOM   = 200;

    typedef struct packed {
        logic              issued;          // slot carried an instruction from the source
        logic              wb_valid;
        isa_pkg::reg_idx_t wb_reg;
        isa_pkg::word_t    wb_data;
        logic              redirect_valid;
        isa_pkg::word_t    redirect_pc;
    } expect_t;

    logic              clk;
    logic              reset;
    logic              in_valid;
    isa_pkg::word_t    instr;
    isa_pkg::word_t    pc;
    logic              wb_valid;
    isa_pkg::reg_idx_t wb_reg;
    isa_pkg::word_t    wb_data;
    logic              redirect_valid;
    isa_pkg::word_t    redirect_pc;

    isa_pkg::word_t    model_regs [32];          // architectural registers
    logic [7:0]        model_mem [DMEM_BYTES];   // byte memory model
    expect_t           exp_q [$];                // one entry per issue slot
    expect_t           exp_now;                  // head, due at the next edge
    isa_pkg::reg_idx_t recent [2];               // dests of the last two slots
    isa_pkg::word_t    cur_pc;
    int                errors;
    int                n_issued;
    int                n_wb;
    int                n_redirect;

    ppu_core_top #(.DMEM_BYTES(DMEM_BYTES)) i_dut (
        .clk, .reset, .in_valid, .instr, .pc,
        .wb_valid, .wb_reg, .wb_data, .redirect_valid, .redirect_pc
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic log_mismatch(input string what, input isa_pkg::word_t got,
                                input isa_pkg::word_t want);
        errors++;
        $display("** Error at %0t: %s got %h expected %h", $time, what, got, want);
    endtask

    // outputs seen at an edge belong to the slot issued three edges earlier
    wb_valid_chk: assert property (@(posedge clk) disable iff (reset)
        wb_valid == exp_now.wb_valid)
        else log_mismatch("wb_valid", $sampled(wb_valid), exp_now.wb_valid);
    wb_reg_chk: assert property (@(posedge clk) disable iff (reset)
        exp_now.wb_valid |-> wb_reg == exp_now.wb_reg)
        else log_mismatch("wb_reg", $sampled(wb_reg), exp_now.wb_reg);
    wb_data_chk: assert property (@(posedge clk) disable iff (reset)
        exp_now.wb_valid |-> wb_data == exp_now.wb_data)
        else log_mismatch("wb_data", $sampled(wb_data), exp_now.wb_data);
    redir_valid_chk: assert property (@(posedge clk) disable iff (reset)
        redirect_valid == exp_now.redirect_valid)
        else log_mismatch("redirect_valid", $sampled(redirect_valid), exp_now.redirect_valid);
    redir_pc_chk: assert property (@(posedge clk) disable iff (reset)
        exp_now.redirect_valid |-> redirect_pc == exp_now.redirect_pc)
        else log_mismatch("redirect_pc", $sampled(redirect_pc), exp_now.redirect_pc);

    function automatic isa_pkg::word_t itype_word(input isa_pkg::opcode_t op,
            input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic isa_pkg::word_t rtype_word(input isa_pkg::reg_idx_t rs,
            input isa_pkg::reg_idx_t rt, input isa_pkg::reg_idx_t rd, input isa_pkg::funct_t fn);
        return {isa_pkg::R_TYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    task automatic write_back(inout expect_t e, input isa_pkg::reg_idx_t d,
                              input isa_pkg::word_t v);
        if (d != '0) begin  // r0 writes vanish
            model_regs[d] = v;
            e.wb_valid    = 1'b1;
            e.wb_reg      = d;
            e.wb_data     = v;
            n_wb++;
        end
    endtask

    // reference model, straight from the instruction rules
    task automatic model_step(input isa_pkg::word_t ins, input isa_pkg::word_t at_pc,
                              output expect_t e);
        isa_pkg::reg_idx_t rs;
        isa_pkg::reg_idx_t rt;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    a;
        isa_pkg::word_t    b;
        isa_pkg::word_t    sext;
        isa_pkg::word_t    addr;
        isa_pkg::word_t    pc4;
        rs   = ins[25:21];
        rt   = ins[20:16];
        rd   = ins[15:11];
        a    = model_regs[rs];
        b    = model_regs[rt];
        sext = {{16{ins[15]}}, ins[15:0]};
        addr = (a + sext) % DMEM_BYTES;  // memory wraps
        pc4  = at_pc + 32'd4;
        e    = '0;
        if (ins != '0) begin
            case (ins[31:26])
                isa_pkg::R_TYPE: begin
                    if (ins[5:0] == isa_pkg::SUBU_FUNCT) begin
                        write_back(e, rd, a - b);
                    end else if (ins[5:0] == isa_pkg::JR_FUNCT) begin
                        e.redirect_valid = 1'b1;
                        e.redirect_pc    = a;
                    end
                end
                isa_pkg::ADDIU_OP: write_back(e, rt, a + sext);
                isa_pkg::LBU_OP:   write_back(e, rt, {24'h0, model_mem[addr]});
                isa_pkg::SB_OP:    model_mem[addr] = b[7:0];
                isa_pkg::BGTZ_OP: begin
                    if ($signed(a) > 0) begin  // zero and negative fall through
                        e.redirect_valid = 1'b1;
                        e.redirect_pc    = pc4 + (sext << 2);
                    end
                end
                isa_pkg::JAL_OP: begin
                    write_back(e, isa_pkg::LINK_REG, at_pc + 32'd8);
                    e.redirect_valid = 1'b1;
                    e.redirect_pc    = {pc4[31:28], ins[25:0], 2'b00};
                end
                isa_pkg::LUI_OP:   write_back(e, rt, {ins[15:0], 16'h0});
                default: ;  // unknown opcode, no effect
            endcase
        end
        if (e.redirect_valid) n_redirect++;
    endtask

    // one issue slot, every cycle goes through here so the queue stays aligned
    task automatic issue(input logic valid, input isa_pkg::word_t ins);
        expect_t e;
        @(posedge clk);
        #2;
        in_valid = valid;
        instr    = valid ? ins : '0;
        pc       = cur_pc;
        e        = '0;
        if (valid) begin
            model_step(ins, cur_pc, e);
            e.issued = 1'b1;
            cur_pc = cur_pc + 32'd4;
            n_issued++;
        end
        exp_q.push_back(e);
        if (exp_q.size() > 3) exp_now = exp_q.pop_front();
    endtask

    task automatic idle_cycle();
        issue(1'b0, '0);
    endtask

    // idles until a write-back strobe shows up, returns the slots it took
    task automatic wait_wb_strobe(input int limit, output int cycles);
        cycles = 0;
        while (!wb_valid && cycles < limit) begin
            idle_cycle();
            cycles++;
        end
        if (!wb_valid) begin
            errors++;
            $display("timeout: no write-back strobe within %0d cycles", limit);
        end
    endtask

    // let every queued expectation reach the checkers
    task automatic drain(input int limit);
        int  n;
        logic busy;
        n    = 0;
        busy = 1'b1;
        while (busy && n < limit) begin
            idle_cycle();
            n++;
            busy = exp_now.issued;
            foreach (exp_q[i]) busy |= exp_q[i].issued;
        end
        if (busy) begin
            errors++;
            $display("timeout: issued slots still unchecked after %0d idle cycles", limit);
        end
    endtask

    // source register not written by either of the two previous slots
    function automatic isa_pkg::reg_idx_t pick_src();
        isa_pkg::reg_idx_t r;
        r = '0;
        for (int i = 0; i < 8; i++) begin
            r = 5'($urandom_range(0, 8));
            if (r == 5'd8) r = isa_pkg::LINK_REG;
            if (r != recent[0] && r != recent[1]) return r;
        end
        return '0;  // r0 never changes
    endfunction

    task automatic random_instr(output isa_pkg::word_t ins, output isa_pkg::reg_idx_t dest);
        int                kind;
        isa_pkg::reg_idx_t s;
        isa_pkg::reg_idx_t t;
        isa_pkg::reg_idx_t d;
        logic [15:0]       imm;
        kind = $urandom_range(0, 9);
        s    = pick_src();
        t    = pick_src();
        d    = 5'($urandom_range(0, 7));  // r0 now and then
        imm  = 16'($urandom());
        dest = '0;
        case (kind)
            0: begin ins = itype_word(isa_pkg::ADDIU_OP, s, d, imm); dest = d; end
            1: begin ins = rtype_word(s, t, d, isa_pkg::SUBU_FUNCT); dest = d; end
            2: begin ins = itype_word(isa_pkg::LBU_OP, s, d, imm); dest = d; end
            3: ins = itype_word(isa_pkg::SB_OP, s, t, imm);
            4: ins = itype_word(isa_pkg::BGTZ_OP, s, 5'd0, imm);
            5: begin ins = {isa_pkg::JAL_OP, 26'($urandom())}; dest = isa_pkg::LINK_REG; end
            6: ins = rtype_word(s, 5'd0, 5'd0, isa_pkg::JR_FUNCT);
            7: begin ins = itype_word(isa_pkg::LUI_OP, 5'd0, d, imm); dest = d; end
            8: ins = {6'h3f, 26'($urandom())};  // unused opcode
            default: ins = '0;
        endcase
    endtask

    initial begin
        isa_pkg::word_t    ins;
        isa_pkg::reg_idx_t d;
        int                lat;
        void'($urandom(SEED));
        reset    = 1'b1;
        in_valid = 1'b0;
        instr    = '0;
        pc       = '0;
        cur_pc   = 32'h0040_0000;
        exp_now  = '0;
        recent   = '{default: '0};
        errors   = 0;
        n_issued = 0;
        n_wb     = 0;
        n_redirect = 0;
        foreach (model_regs[i]) model_regs[i] = '0;
        foreach (model_mem[i]) model_mem[i] = '0;
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;

        // quiet after reset, nop and unknown codes stay silent
        repeat (4) idle_cycle();
        issue(1'b1, '0);
        issue(1'b1, {6'h3f, 26'h155_aaaa});
        issue(1'b1, rtype_word(5'd0, 5'd0, 5'd1, 6'h20));  // add, not in the subset
        drain(8);

        // alu results and exact latency
        issue(1'b1, itype_word(isa_pkg::ADDIU_OP, 5'd0, 5'd1, 16'd100));
        wait_wb_strobe(6, lat);
        latency_chk: assert (lat == 3)
            else log_mismatch("write-back latency", lat, 3);
        issue(1'b1, itype_word(isa_pkg::ADDIU_OP, 5'd0, 5'd2, 16'hfffb));  // -5
        issue(1'b1, itype_word(isa_pkg::ADDIU_OP, 5'd0, 5'd5, 16'd300));   // wraps to 44
        issue(1'b1, itype_word(isa_pkg::ADDIU_OP, 5'd0, 5'd8, 16'hfffe));
        issue(1'b1, rtype_word(5'd1, 5'd2, 5'd3, isa_pkg::SUBU_FUNCT));    // 105
        issue(1'b1, itype_word(isa_pkg::LUI_OP, 5'd0, 5'd4, 16'habcd));
        issue(1'b1, itype_word(isa_pkg::ADDIU_OP, 5'd1, 5'd0, 16'd7));     // r0, no strobe

        // byte store then load, modulo address, zero extension
        issue(1'b1, itype_word(isa_pkg::SB_OP, 5'd5, 5'd8, 16'd1));
        issue(1'b1, itype_word(isa_pkg::SB_OP, 5'd5, 5'd3, 16'd0));
        issue(1'b1, itype_word(isa_pkg::LBU_OP, 5'd5, 5'd6, 16'd0));
        issue(1'b1, itype_word(isa_pkg::LBU_OP, 5'd5, 5'd7, 16'hff00));  // same byte, -256
        issue(1'b1, itype_word(isa_pkg::LBU_OP, 5'd5, 5'd9, 16'd1));     // 0xfe

        // bgtz, taken only for positive rs
        issue(1'b1, itype_word(isa_pkg::BGTZ_OP, 5'd1, 5'd0, 16'd3));
        issue(1'b1, itype_word(isa_pkg::BGTZ_OP, 5'd0, 5'd0, 16'd5));
        issue(1'b1, itype_word(isa_pkg::BGTZ_OP, 5'd2, 5'd0, 16'd5));
        issue(1'b1, itype_word(isa_pkg::BGTZ_OP, 5'd4, 5'd0, 16'd5));
        issue(1'b1, itype_word(isa_pkg::BGTZ_OP, 5'd1, 5'd0, 16'hfffc));  // backward

        // jal links, jr jumps without writing
        issue(1'b1, {isa_pkg::JAL_OP, 26'h012_3456});
        issue(1'b1, rtype_word(5'd1, 5'd0, 5'd0, isa_pkg::JR_FUNCT));
        issue(1'b1, rtype_word(5'd6, 5'd7, 5'd10, isa_pkg::SUBU_FUNCT));
        issue(1'b1, rtype_word(isa_pkg::LINK_REG, 5'd0, 5'd0, isa_pkg::JR_FUNCT));
        issue(1'b1, itype_word(isa_pkg::LUI_OP, 5'd0, 5'd0, 16'h1234));
        drain(8);

        // back to back random stream
        for (int i = 0; i < N_RANDOM; i++) begin
            random_instr(ins, d);
            issue(1'b1, ins);
            recent[1] = recent[0];
            recent[0] = d;
        end
        drain(8);

        $display("issued %0d, write-backs %0d, redirects %0d, errors %0d",
                 n_issued, n_wb, n_redirect, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
design/isa_pkg.sv
design/ctrl_pkg.sv
design/instr_intake.sv
design/ppu_control_unit.sv
design/reg_file.sv
design/exec_unit.sv
design/commit_stage.sv
design/ppu_core_top.sv
bench/tb_ppu_core.sv

/* Bender.yml */
package:
  name: ppu_core

sources:
  - files:
      - design/isa_pkg.sv
      - design/ctrl_pkg.sv
      - design/instr_intake.sv
      - design/ppu_control_unit.sv
      - design/reg_file.sv
      - design/exec_unit.sv
      - design/commit_stage.sv
      - design/ppu_core_top.sv
  - target: simulation
    files:
      - bench/tb_ppu_core.sv
